// ==== common/cnn_pkg.sv ====
`default_nettype none

package cnn_pkg;

    localparam int unsigned addr_width = 10;

    typedef logic [addr_width-1:0] addr_t;

    // kernel and window geometry.
    localparam addr_t kernel_side = addr_t'(3);
    localparam addr_t pool_side   = addr_t'(2);

    // memory map.
    localparam addr_t region_a_base  = addr_t'(0);   // input image, pool output.
    localparam addr_t region_b_base  = addr_t'(128); // conv output, relu in place.
    localparam addr_t weight_base_l0 = addr_t'(0);
    localparam addr_t weight_base_l1 = addr_t'(9);

    typedef enum logic {
        LAYER_0,
        LAYER_1
    } layer_t;

    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_LOAD,   // new sum from current product.
        MAC_ACC,
        MAC_NORM    // normalise and present for write.
    } mac_op_t;

    typedef enum logic [1:0] {
        CMP_IDLE,
        CMP_LOAD,
        CMP_MAX
    } cmp_op_t;

    typedef enum logic [1:0] {
        RES_MAC,
        RES_RELU,
        RES_POOL
    } result_sel_t;

    typedef enum logic [1:0] {
        IDLE,
        CONV,
        RELU,
        POOL
    } phase_t;

    typedef struct packed {
        addr_t       picture_addr;
        logic        picture_we;
        addr_t       weight_addr;
        mac_op_t     mac_op;
        cmp_op_t     cmp_op;
        result_sel_t result_sel;
    } mem_cmd_t;

    // input side of a layer, layer 1 reads the pooled layer 0 map.
    function automatic addr_t layer_side(input layer_t layer, input int unsigned img_side);
        if (layer == LAYER_0) begin
            return addr_t'(img_side);
        end
        return addr_t'((img_side - 2) / 2);
    endfunction

    // conv output side of a layer.
    function automatic addr_t conv_side(input layer_t layer, input int unsigned img_side);
        return layer_side(layer, img_side) - (kernel_side - addr_t'(1));
    endfunction

endpackage

`default_nettype wire

// ==== verilog/layer_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module layer_sequencer #(
    parameter int unsigned img_side = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_valid,
    output logic              start_ready,
    input  logic              cmd_ready,
    output logic              cmd_valid,
    output cnn_pkg::mem_cmd_t cmd,
    output logic              busy,
    output logic              done,
    output cnn_pkg::layer_t   layer,
    output logic              conv_step,
    output logic              relu_step,
    output logic              pool_step,
    input  cnn_pkg::mem_cmd_t conv_cmd,
    input  cnn_pkg::mem_cmd_t relu_cmd,
    input  cnn_pkg::mem_cmd_t pool_cmd,
    input  logic              conv_last,
    input  logic              relu_last,
    input  logic              pool_last
);

    cnn_pkg::phase_t state;
    logic            beat;

    assign busy        = (state != cnn_pkg::IDLE);
    assign start_ready = ~busy;
    assign cmd_valid   = busy; // a scheduler always has a beat ready.
    assign beat        = cmd_valid & cmd_ready;

    // only the active scheduler sees the accepted beat.
    assign conv_step = beat && (state == cnn_pkg::CONV);
    assign relu_step = beat && (state == cnn_pkg::RELU);
    assign pool_step = beat && (state == cnn_pkg::POOL);

    always_comb begin
        case (state)
            cnn_pkg::CONV: cmd = conv_cmd;
            cnn_pkg::RELU: cmd = relu_cmd;
            cnn_pkg::POOL: cmd = pool_cmd;
            default:       cmd = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cnn_pkg::IDLE;
            layer <= cnn_pkg::LAYER_0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                cnn_pkg::IDLE: begin
                    if (start_valid) begin
                        state <= cnn_pkg::CONV;
                        layer <= cnn_pkg::LAYER_0;
                    end
                end
                cnn_pkg::CONV: begin
                    if (conv_step && conv_last) begin
                        state <= cnn_pkg::RELU;
                    end
                end
                cnn_pkg::RELU: begin
                    if (relu_step && relu_last) begin
                        state <= cnn_pkg::POOL;
                    end
                end
                cnn_pkg::POOL: begin
                    if (pool_step && pool_last) begin
                        if (layer == cnn_pkg::LAYER_0) begin
                            state <= cnn_pkg::CONV;
                            layer <= cnn_pkg::LAYER_1;
                        end else begin
                            state <= cnn_pkg::IDLE; // run complete.
                            done  <= 1'b1;
                        end
                    end
                end
                default: state <= cnn_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== scheduler/conv_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_scheduler #(
    parameter int unsigned img_side = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cnn_pkg::layer_t   layer,
    input  logic              step,
    output cnn_pkg::mem_cmd_t cmd,
    output logic              last
);

    localparam cnn_pkg::addr_t k_last = cnn_pkg::kernel_side - cnn_pkg::addr_t'(1);

    cnn_pkg::addr_t n;
    cnn_pkg::addr_t m;
    cnn_pkg::addr_t w_base;
    cnn_pkg::addr_t out_r;
    cnn_pkg::addr_t out_c;
    cnn_pkg::addr_t k_r;
    cnn_pkg::addr_t k_c;
    logic           wr;     // write beat after the nine reads.
    logic           out_c_end;

    assign n      = cnn_pkg::layer_side(layer, img_side);
    assign m      = cnn_pkg::conv_side(layer, img_side);
    assign w_base = (layer == cnn_pkg::LAYER_0) ? cnn_pkg::weight_base_l0
                                                : cnn_pkg::weight_base_l1;

    assign out_c_end = (out_c == m - cnn_pkg::addr_t'(1));
    assign last      = wr && out_c_end && (out_r == m - cnn_pkg::addr_t'(1));

    always_comb begin
        cmd = '0;
        if (wr) begin
            cmd.picture_addr = cnn_pkg::region_b_base + out_r * m + out_c;
            cmd.picture_we   = 1'b1;
            cmd.mac_op       = cnn_pkg::MAC_NORM;
            cmd.result_sel   = cnn_pkg::RES_MAC;
        end else begin
            cmd.picture_addr = cnn_pkg::region_a_base + (out_r + k_r) * n + (out_c + k_c);
            cmd.weight_addr  = w_base + k_r * cnn_pkg::kernel_side + k_c;
            cmd.mac_op       = (k_r == '0 && k_c == '0) ? cnn_pkg::MAC_LOAD : cnn_pkg::MAC_ACC;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_r <= '0;
            out_c <= '0;
            k_r   <= '0;
            k_c   <= '0;
            wr    <= 1'b0;
        end else if (step) begin
            if (wr) begin
                wr <= 1'b0;
                if (last) begin
                    out_r <= '0; // wrap for the next layer.
                    out_c <= '0;
                end else if (out_c_end) begin
                    out_c <= '0;
                    out_r <= out_r + cnn_pkg::addr_t'(1);
                end else begin
                    out_c <= out_c + cnn_pkg::addr_t'(1);
                end
            end else if (k_c == k_last) begin
                k_c <= '0;
                if (k_r == k_last) begin
                    k_r <= '0;
                    wr  <= 1'b1;
                end else begin
                    k_r <= k_r + cnn_pkg::addr_t'(1);
                end
            end else begin
                k_c <= k_c + cnn_pkg::addr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== scheduler/relu_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module relu_scheduler #(
    parameter int unsigned img_side = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cnn_pkg::layer_t   layer,
    input  logic              step,
    output cnn_pkg::mem_cmd_t cmd,
    output logic              last
);

    cnn_pkg::addr_t m;
    cnn_pkg::addr_t idx;
    logic           wr;

    assign m    = cnn_pkg::conv_side(layer, img_side);
    assign last = wr && (idx == m * m - cnn_pkg::addr_t'(1));

    // read then write back the same word.
    always_comb begin
        cmd              = '0;
        cmd.picture_addr = cnn_pkg::region_b_base + idx;
        if (wr) begin
            cmd.picture_we = 1'b1;
            cmd.result_sel = cnn_pkg::RES_RELU;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
            wr  <= 1'b0;
        end else if (step) begin
            wr <= ~wr;
            if (last) begin
                idx <= '0;
            end else if (wr) begin
                idx <= idx + cnn_pkg::addr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== scheduler/pool_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module pool_scheduler #(
    parameter int unsigned img_side = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cnn_pkg::layer_t   layer,
    input  logic              step,
    output cnn_pkg::mem_cmd_t cmd,
    output logic              last
);

    localparam cnn_pkg::addr_t win_last =
        cnn_pkg::pool_side * cnn_pkg::pool_side - cnn_pkg::addr_t'(1);

    cnn_pkg::addr_t m;
    cnn_pkg::addr_t p;      // pooled side.
    cnn_pkg::addr_t pr;
    cnn_pkg::addr_t pc;
    cnn_pkg::addr_t win;
    cnn_pkg::addr_t win_i;
    cnn_pkg::addr_t win_j;
    logic           wr;
    logic           pc_end;

    assign m     = cnn_pkg::conv_side(layer, img_side);
    assign p     = m / cnn_pkg::pool_side;
    assign win_i = win / cnn_pkg::pool_side;
    assign win_j = win % cnn_pkg::pool_side;

    assign pc_end = (pc == p - cnn_pkg::addr_t'(1));
    assign last   = wr && pc_end && (pr == p - cnn_pkg::addr_t'(1));

    always_comb begin
        cmd = '0;
        if (wr) begin
            cmd.picture_addr = cnn_pkg::region_a_base + pr * p + pc;
            cmd.picture_we   = 1'b1;
            cmd.result_sel   = cnn_pkg::RES_POOL;
        end else begin
            cmd.picture_addr = cnn_pkg::region_b_base
                             + (pr * cnn_pkg::pool_side + win_i) * m
                             + (pc * cnn_pkg::pool_side + win_j);
            cmd.cmp_op       = (win == '0) ? cnn_pkg::CMP_LOAD : cnn_pkg::CMP_MAX;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pr  <= '0;
            pc  <= '0;
            win <= '0;
            wr  <= 1'b0;
        end else if (step) begin
            if (wr) begin
                wr <= 1'b0;
                if (last) begin
                    pr <= '0;
                    pc <= '0;
                end else if (pc_end) begin
                    pc <= '0;
                    pr <= pr + cnn_pkg::addr_t'(1);
                end else begin
                    pc <= pc + cnn_pkg::addr_t'(1);
                end
            end else if (win == win_last) begin
                win <= '0;
                wr  <= 1'b1; // window done, write the max.
            end else begin
                win <= win + cnn_pkg::addr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cnn_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnn_controller #(
    parameter int unsigned img_side = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_valid,
    output logic              start_ready,
    output cnn_pkg::mem_cmd_t cmd,
    output logic              cmd_valid,
    input  logic              cmd_ready,
    output logic              busy,
    output logic              done
);

    cnn_pkg::layer_t   layer;
    cnn_pkg::mem_cmd_t conv_cmd;
    cnn_pkg::mem_cmd_t relu_cmd;
    cnn_pkg::mem_cmd_t pool_cmd;
    logic              conv_step;
    logic              relu_step;
    logic              pool_step;
    logic              conv_last;
    logic              relu_last;
    logic              pool_last;

    layer_sequencer #(
        .img_side    (img_side)
    ) u_layer_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .cmd_ready   (cmd_ready),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .busy        (busy),
        .done        (done),
        .layer       (layer),
        .conv_step   (conv_step),
        .relu_step   (relu_step),
        .pool_step   (pool_step),
        .conv_cmd    (conv_cmd),
        .relu_cmd    (relu_cmd),
        .pool_cmd    (pool_cmd),
        .conv_last   (conv_last),
        .relu_last   (relu_last),
        .pool_last   (pool_last)
    );

    conv_scheduler #(
        .img_side (img_side)
    ) u_conv_scheduler (
        .clk      (clk),
        .rst_n    (rst_n),
        .layer    (layer),
        .step     (conv_step),
        .cmd      (conv_cmd),
        .last     (conv_last)
    );

    relu_scheduler #(
        .img_side (img_side)
    ) u_relu_scheduler (
        .clk      (clk),
        .rst_n    (rst_n),
        .layer    (layer),
        .step     (relu_step),
        .cmd      (relu_cmd),
        .last     (relu_last)
    );

    pool_scheduler #(
        .img_side (img_side)
    ) u_pool_scheduler (
        .clk      (clk),
        .rst_n    (rst_n),
        .layer    (layer),
        .step     (pool_step),
        .cmd      (pool_cmd),
        .last     (pool_last)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/cnn_controller_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnn_controller_assertions (
    input logic              clk,
    input logic              rst_n,
    input cnn_pkg::mem_cmd_t cmd,
    input logic              cmd_valid,
    input logic              cmd_ready,
    input logic              busy,
    input logic              done
);

    int unsigned error_count = 0;

    // a stalled beat must be presented again unchanged.
    cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else begin
            error_count++;
            $error("cmd changed or was dropped while stalled");
        end

    valid_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !cmd_valid)
        else begin
            error_count++;
            $error("cmd_valid high while not busy");
        end

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy ##1 !done)
        else begin
            error_count++;
            $error("done longer than one cycle or busy still high");
        end

endmodule

bind cnn_controller cnn_controller_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .busy      (busy),
    .done      (done)
);

`default_nettype wire

// ==== testbench/tb_cnn_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_controller;

    localparam int img_side       = 10;
    localparam int run_beats      = 901;
    localparam int n_rows         = 6;
    localparam int timeout_cycles = n_rows * 4 * run_beats + 1000;

    typedef struct packed {
        logic [3:0] gap;          // idle cycles before start.
        logic       random_ready;
        logic       restart;      // keep start_valid high during the run.
    } row_t;

    localparam row_t stim_table [n_rows] = '{
        '{gap: 4'd1, random_ready: 1'b0, restart: 1'b0},
        '{gap: 4'd3, random_ready: 1'b1, restart: 1'b0},
        '{gap: 4'd2, random_ready: 1'b0, restart: 1'b1},
        '{gap: 4'd1, random_ready: 1'b1, restart: 1'b1},
        '{gap: 4'd5, random_ready: 1'b1, restart: 1'b0},
        '{gap: 4'd1, random_ready: 1'b0, restart: 1'b0}
    };

    logic              clk;
    logic              rst_n;
    logic              start_valid;
    logic              start_ready;
    cnn_pkg::mem_cmd_t cmd;
    logic              cmd_valid;
    logic              cmd_ready;
    logic              busy;
    logic              done;

    cnn_pkg::mem_cmd_t expected [$];
    logic [7:0]        lfsr;
    int                cycles;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cnn_controller #(
        .img_side    (img_side)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .busy        (busy),
        .done        (done)
    );

    task automatic check(input bit cond, input string msg);
        assert (cond) else begin
            $display("[ERROR] time %0t: %s", $time, msg);
            $display("TEST FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // x^8 + x^6 + x^5 + x^4 + 1.
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic logic next_ready_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    function automatic void push_beat(input int addr, input logic we, input int waddr,
                                      input cnn_pkg::mac_op_t mac, input cnn_pkg::cmp_op_t cmp,
                                      input cnn_pkg::result_sel_t res);
        cnn_pkg::mem_cmd_t c;
        c.picture_addr = cnn_pkg::addr_t'(addr);
        c.picture_we   = we;
        c.weight_addr  = cnn_pkg::addr_t'(waddr);
        c.mac_op       = mac;
        c.cmp_op       = cmp;
        c.result_sel   = res;
        expected.push_back(c);
    endfunction

    // expected beat list of a whole run over both layers.
    task automatic build_model();
        int n, m, p, wb, ks, ps, a_base, b_base;
        int l, r, c, i, j, w;
        cnn_pkg::mac_op_t mac;
        cnn_pkg::cmp_op_t cmp;
        ks     = int'(cnn_pkg::kernel_side);
        ps     = int'(cnn_pkg::pool_side);
        a_base = int'(cnn_pkg::region_a_base);
        b_base = int'(cnn_pkg::region_b_base);
        expected.delete();
        for (l = 0; l < 2; l++) begin
            n  = (l == 0) ? img_side : (img_side - 2) / 2;
            m  = n - 2;
            p  = m / ps;
            wb = (l == 0) ? int'(cnn_pkg::weight_base_l0) : int'(cnn_pkg::weight_base_l1);
            for (r = 0; r < m; r++) begin
                for (c = 0; c < m; c++) begin
                    for (i = 0; i < ks; i++) begin
                        for (j = 0; j < ks; j++) begin
                            mac = (i == 0 && j == 0) ? cnn_pkg::MAC_LOAD : cnn_pkg::MAC_ACC;
                            push_beat(a_base + (r + i) * n + c + j, 1'b0, wb + i * ks + j,
                                      mac, cnn_pkg::CMP_IDLE, cnn_pkg::RES_MAC);
                        end
                    end
                    push_beat(b_base + r * m + c, 1'b1, 0, cnn_pkg::MAC_NORM,
                              cnn_pkg::CMP_IDLE, cnn_pkg::RES_MAC);
                end
            end
            for (w = 0; w < m * m; w++) begin
                push_beat(b_base + w, 1'b0, 0, cnn_pkg::MAC_IDLE, cnn_pkg::CMP_IDLE,
                          cnn_pkg::RES_MAC);
                push_beat(b_base + w, 1'b1, 0, cnn_pkg::MAC_IDLE, cnn_pkg::CMP_IDLE,
                          cnn_pkg::RES_RELU);
            end
            for (r = 0; r < p; r++) begin
                for (c = 0; c < p; c++) begin
                    for (i = 0; i < ps; i++) begin
                        for (j = 0; j < ps; j++) begin
                            cmp = (i == 0 && j == 0) ? cnn_pkg::CMP_LOAD : cnn_pkg::CMP_MAX;
                            push_beat(b_base + (ps * r + i) * m + ps * c + j, 1'b0, 0,
                                      cnn_pkg::MAC_IDLE, cmp, cnn_pkg::RES_MAC);
                        end
                    end
                    push_beat(a_base + r * p + c, 1'b1, 0, cnn_pkg::MAC_IDLE,
                              cnn_pkg::CMP_IDLE, cnn_pkg::RES_POOL);
                end
            end
        end
    endtask

    task automatic check_idle();
        check(!busy && !done && !cmd_valid && start_ready, "controller not idle");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        row_t              row;
        int                beats;
        logic              stalled;
        logic              finished;
        cnn_pkg::mem_cmd_t held;
        start_valid = 1'b0;
        cmd_ready   = 1'b0;
        lfsr        = 8'd74;
        cycles      = 0;
        build_model();
        check(expected.size() == run_beats, "model beat list has wrong length");
        @(posedge rst_n);
        @(negedge clk);
        check_idle();
        for (int k = 0; k < n_rows; k++) begin
            row = stim_table[k];
            repeat (row.gap) begin
                @(negedge clk);
                check_idle();
            end
            start_valid = 1'b1;
            beats       = 0;
            stalled     = 1'b0;
            finished    = 1'b0;
            while (!finished) begin
                @(negedge clk);
                if (done) begin
                    check(!busy && !cmd_valid, "busy or cmd_valid high with done");
                    check(beats == run_beats,
                          $sformatf("run ended after %0d beats", beats));
                    start_valid = 1'b0;
                    cmd_ready   = 1'b0;
                    finished    = 1'b1;
                end else begin
                    start_valid = row.restart;
                    check(busy && cmd_valid && !start_ready, "not busy during run");
                    if (stalled) begin
                        check(cmd == held, "cmd changed while stalled");
                    end
                    cmd_ready = row.random_ready ? next_ready_bit() : 1'b1;
                    if (cmd_ready) begin
                        check(beats < run_beats, "beat past end of run");
                        check(cmd == expected[beats],
                              $sformatf("beat %0d got %h expected %h",
                                        beats, cmd, expected[beats]));
                        beats++;
                    end
                    stalled = !cmd_ready;
                    held    = cmd;
                end
            end
        end
        @(negedge clk);
        check_idle();
        if (DUT.u_assertions.error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("bound assertions failed %0d times", DUT.u_assertions.error_count);
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/cnn_pkg.sv
verilog/layer_sequencer.sv
scheduler/conv_scheduler.sv
scheduler/relu_scheduler.sv
scheduler/pool_scheduler.sv
verilog/cnn_controller.sv
testbench/tb_clock_gen.sv
testbench/cnn_controller_assertions.sv
testbench/tb_cnn_controller.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cnn_controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cnn_controller -f tb.f \
    && ./obj_dir/Vtb_cnn_controller | tee /dev/stderr | grep -F "TEST PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
